//--- monoVgaPkg.sv
`default_nettype none

package monoVgaPkg;

  // host bus.
  localparam int busAddrWidth = 24;
  localparam int busDataWidth = 32; // also pixels per frame-buffer word.

  localparam int pixelWidth = 9;

  localparam logic [busAddrWidth-1:0] scrollRegAddr = 24'h050000;

  // shared by the horizontal and vertical counters.
  typedef enum logic [1:0] {
    syncPhase,
    backPhase,
    activePhase,
    frontPhase
  } linePhase;

endpackage

`default_nettype wire

//--- videoTimingIf.sv
`default_nettype none
`timescale 1ns/100ps

interface videoTimingIf;

  logic de;
  logic hsync;
  logic vsync;
  logic frameStart; // one cycle, both counters at zero.

  modport source (
    output de, hsync, vsync, frameStart
  );

  modport sink (
    input de, hsync, vsync, frameStart
  );

endinterface

`default_nettype wire

//--- resetSync.sv
`default_nettype none
`timescale 1ns/100ps

module resetSync (
  input  logic clk,
  input  logic rstInN,
  output logic rstOutN
);

  logic stageN;

  always_ff @(posedge clk or negedge rstInN) begin
    if (!rstInN) begin
      stageN  <= 1'b0;
      rstOutN <= 1'b0;
    end else begin
      stageN  <= 1'b1;
      rstOutN <= stageN; // release on second edge.
    end
  end

endmodule

`default_nettype wire

//--- hostWritePort.sv
`default_nettype none
`timescale 1ns/100ps

module hostWritePort
  import monoVgaPkg::*;
#(
  parameter int frameWords    = 15000,
  parameter int wordAddrWidth = $clog2(frameWords)
) (
  input  logic                     clk_bus,
  input  logic                     busRstN,
  input  logic [busAddrWidth-1:0]  busAddress,
  input  logic [busDataWidth-1:0]  busWriteData,
  input  logic                     busWrite,
  output logic                     ramWrite,
  output logic [wordAddrWidth-1:0] ramAddr,
  output logic [busDataWidth-1:0]  ramData,
  output logic [wordAddrWidth-1:0] scrollValue,
  output logic                     scrollToggle
);

  logic [13:0] wordIndex;
  logic        scrollHit;
  logic        frameHit;

  assign wordIndex = busAddress[15:2];
  assign scrollHit = busWrite && (busAddress == scrollRegAddr);
  assign frameHit  = busWrite && !scrollHit && (wordIndex < frameWords);

  always_ff @(posedge clk_bus or negedge busRstN) begin
    if (!busRstN) begin
      ramWrite     <= 1'b0;
      scrollValue  <= '0;
      scrollToggle <= 1'b0;
    end else begin
      ramWrite <= frameHit;
      if (scrollHit && (busWriteData < frameWords)) begin
        scrollValue  <= busWriteData[wordAddrWidth-1:0];
        scrollToggle <= !scrollToggle; // one flip per accepted write.
      end
    end
  end

  always_ff @(posedge clk_bus) begin
    if (frameHit) begin
      ramAddr <= wordIndex[wordAddrWidth-1:0];
      ramData <= busWriteData;
    end
  end

endmodule

`default_nettype wire

//--- scrollCrossing.sv
`default_nettype none
`timescale 1ns/100ps

module scrollCrossing #(
  parameter int frameWords    = 15000,
  parameter int wordAddrWidth = $clog2(frameWords)
) (
  input  logic                     clk_pixel,
  input  logic                     pixRstN,
  input  logic [wordAddrWidth-1:0] scrollValue,
  input  logic                     scrollToggle,
  input  logic                     frameStart,
  output logic [wordAddrWidth-1:0] activeScroll
);

  logic [1:0]               toggleSync;
  logic                     toggleLast;
  logic [wordAddrWidth-1:0] pendingScroll;
  logic                     toggleEdge;

  assign toggleEdge = toggleSync[1] ^ toggleLast;

  always_ff @(posedge clk_pixel or negedge pixRstN) begin
    if (!pixRstN) begin
      toggleSync    <= '0;
      toggleLast    <= 1'b0;
      pendingScroll <= '0;
      activeScroll  <= '0;
    end else begin
      toggleSync <= {toggleSync[0], scrollToggle};
      toggleLast <= toggleSync[1];
      if (toggleEdge) begin
        pendingScroll <= scrollValue; // bus side is stable by now.
      end
      if (frameStart) begin
        activeScroll <= pendingScroll; // only between frames.
      end
    end
  end

endmodule

`default_nettype wire

//--- frameBufferRam.sv
`default_nettype none
`timescale 1ns/100ps

module frameBufferRam
  import monoVgaPkg::*;
#(
  parameter int frameWords    = 15000,
  parameter int wordAddrWidth = $clog2(frameWords)
) (
  input  logic                     clk_bus,
  input  logic                     ramWrite,
  input  logic [wordAddrWidth-1:0] ramAddr,
  input  logic [busDataWidth-1:0]  ramData,
  input  logic                     clk_pixel,
  input  logic [wordAddrWidth-1:0] readAddr,
  output logic [busDataWidth-1:0]  readData
);

  logic [busDataWidth-1:0] mem [0:frameWords-1];

  always_ff @(posedge clk_bus) begin
    if (ramWrite) begin
      mem[ramAddr] <= ramData;
    end
  end

  always_ff @(posedge clk_pixel) begin
    readData <= mem[readAddr]; // one cycle read latency.
  end

endmodule

`default_nettype wire

//--- videoTiming.sv
`default_nettype none
`timescale 1ns/100ps

module videoTiming
  import monoVgaPkg::*;
#(
  parameter int hActive = 800,
  parameter int hFront  = 56,
  parameter int hSync   = 120,
  parameter int hBack   = 64,
  parameter int vActive = 600,
  parameter int vFront  = 37,
  parameter int vSync   = 6,
  parameter int vBack   = 23
) (
  input  logic         clk_pixel,
  input  logic         pixRstN,
  videoTimingIf.source video
);

  localparam int hTotal = hSync + hBack + hActive + hFront;
  localparam int vTotal = vSync + vBack + vActive + vFront;
  localparam int hWidth = $clog2(hTotal);
  localparam int vWidth = $clog2(vTotal);

  logic [hWidth-1:0] hCount;
  logic [vWidth-1:0] vCount;
  linePhase          hPhase;
  linePhase          vPhase;
  logic              lineEnd;

  // last count position of the given phase.
  function automatic int phaseLast(
    linePhase phase,
    int       syncLen,
    int       backLen,
    int       activeLen,
    int       frontLen
  );
    case (phase)
      syncPhase:   phaseLast = syncLen - 1;
      backPhase:   phaseLast = syncLen + backLen - 1;
      activePhase: phaseLast = syncLen + backLen + activeLen - 1;
      default:     phaseLast = syncLen + backLen + activeLen + frontLen - 1;
    endcase
  endfunction

  assign lineEnd = (hCount == hTotal - 1);

  always_ff @(posedge clk_pixel or negedge pixRstN) begin
    if (!pixRstN) begin
      hCount <= '0;
      vCount <= '0;
      hPhase <= syncPhase;
      vPhase <= syncPhase;
    end else begin
      hCount <= lineEnd ? '0 : hCount + 1'b1;
      if (hCount == phaseLast(hPhase, hSync, hBack, hActive, hFront)) begin
        hPhase <= hPhase.next(); // front wraps to sync.
      end
      if (lineEnd) begin
        vCount <= (vCount == vTotal - 1) ? '0 : vCount + 1'b1;
        if (vCount == phaseLast(vPhase, vSync, vBack, vActive, vFront)) begin
          vPhase <= vPhase.next();
        end
      end
    end
  end

  always_ff @(posedge clk_pixel or negedge pixRstN) begin
    if (!pixRstN) begin
      video.de         <= 1'b0;
      video.hsync      <= 1'b1;
      video.vsync      <= 1'b1;
      video.frameStart <= 1'b0;
    end else begin
      video.de         <= (hPhase == activePhase) && (vPhase == activePhase);
      video.hsync      <= (hPhase == syncPhase); // positive pulse.
      video.vsync      <= (vPhase == syncPhase);
      video.frameStart <= (hCount == '0) && (vCount == '0);
    end
  end

endmodule

`default_nettype wire

//--- pixelFetch.sv
`default_nettype none
`timescale 1ns/100ps

module pixelFetch
  import monoVgaPkg::*;
#(
  parameter int frameWords    = 15000,
  parameter int wordAddrWidth = $clog2(frameWords)
) (
  input  logic                     clk_pixel,
  input  logic                     pixRstN,
  videoTimingIf.sink               video,
  input  logic [wordAddrWidth-1:0] activeScroll,
  input  logic [busDataWidth-1:0]  readData,
  output logic [wordAddrWidth-1:0] readAddr,
  output logic [pixelWidth-1:0]    pixelData,
  output logic                     de,
  output logic                     hsync,
  output logic                     vsync
);

  localparam int bitIdxWidth = $clog2(busDataWidth);

  logic [2:0]               primeStage;
  logic [bitIdxWidth-1:0]   bitIndex;
  logic [busDataWidth-1:0]  currentWord;
  logic [wordAddrWidth-1:0] nextAddr;
  logic                     wordDone;

  // stage 0 sets the first address, stage 2 takes its data.
  assign wordDone = primeStage[2] ||
                    (video.de && (bitIndex == bitIdxWidth'(busDataWidth - 1)));
  assign nextAddr = (readAddr == wordAddrWidth'(frameWords - 1)) ? '0 : readAddr + 1'b1;

  always_ff @(posedge clk_pixel or negedge pixRstN) begin
    if (!pixRstN) begin
      primeStage <= '0;
      readAddr   <= '0;
      bitIndex   <= '0;
    end else begin
      primeStage <= {primeStage[1:0], video.frameStart};
      if (primeStage[0]) begin
        readAddr <= activeScroll; // scroll was applied on frameStart.
      end else if (wordDone) begin
        readAddr <= nextAddr; // prefetch one word ahead.
      end
      if (primeStage[2]) begin
        bitIndex <= '0;
      end else if (video.de) begin
        bitIndex <= bitIndex + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (wordDone) begin
      currentWord <= readData;
    end
  end

  always_ff @(posedge clk_pixel or negedge pixRstN) begin
    if (!pixRstN) begin
      pixelData <= '0;
      de        <= 1'b0;
      hsync     <= 1'b1;
      vsync     <= 1'b1;
    end else begin
      pixelData <= (video.de && currentWord[bitIndex]) ? {pixelWidth{1'b1}} : '0;
      de        <= video.de;
      hsync     <= video.hsync;
      vsync     <= video.vsync;
    end
  end

endmodule

`default_nettype wire

//--- monoVga.sv
`default_nettype none
`timescale 1ns/100ps

module monoVga
  import monoVgaPkg::*;
#(
  parameter int hActive = 800,
  parameter int hFront  = 56,
  parameter int hSync   = 120,
  parameter int hBack   = 64,
  parameter int vActive = 600,
  parameter int vFront  = 37,
  parameter int vSync   = 6,
  parameter int vBack   = 23
) (
  input  logic                    clk_bus,
  input  logic                    clk_pixel,
  input  logic                    pix_rst_n,
  input  logic [busAddrWidth-1:0] busAddress,
  input  logic [busDataWidth-1:0] busWriteData,
  input  logic                    busWrite,
  output logic                    de,
  output logic                    hsync,
  output logic                    vsync,
  output logic [pixelWidth-1:0]   pixelData
);

  localparam int frameWords    = hActive * vActive / busDataWidth;
  localparam int wordAddrWidth = $clog2(frameWords);

  logic                     busRstN;
  logic                     pixRstN;
  logic                     ramWrite;
  logic [wordAddrWidth-1:0] ramAddr;
  logic [busDataWidth-1:0]  ramData;
  logic [wordAddrWidth-1:0] scrollValue;
  logic                     scrollToggle;
  logic [wordAddrWidth-1:0] activeScroll;
  logic [wordAddrWidth-1:0] readAddr;
  logic [busDataWidth-1:0]  readData;

  videoTimingIf videoBus ();

  resetSync busReset_i (.clk(clk_bus), .rstInN(pix_rst_n), .rstOutN(busRstN));
  resetSync pixReset_i (.clk(clk_pixel), .rstInN(pix_rst_n), .rstOutN(pixRstN));

  hostWritePort #(.frameWords(frameWords), .wordAddrWidth(wordAddrWidth)) hostWrite_i (
    .clk_bus(clk_bus), .busRstN(busRstN), .busAddress(busAddress),
    .busWriteData(busWriteData), .busWrite(busWrite), .ramWrite(ramWrite),
    .ramAddr(ramAddr), .ramData(ramData), .scrollValue(scrollValue),
    .scrollToggle(scrollToggle)
  );

  scrollCrossing #(.frameWords(frameWords), .wordAddrWidth(wordAddrWidth)) scroll_i (
    .clk_pixel(clk_pixel), .pixRstN(pixRstN), .scrollValue(scrollValue),
    .scrollToggle(scrollToggle), .frameStart(videoBus.frameStart),
    .activeScroll(activeScroll)
  );

  frameBufferRam #(.frameWords(frameWords), .wordAddrWidth(wordAddrWidth)) frameBuf_i (
    .clk_bus(clk_bus), .ramWrite(ramWrite), .ramAddr(ramAddr), .ramData(ramData),
    .clk_pixel(clk_pixel), .readAddr(readAddr), .readData(readData)
  );

  videoTiming #(
    .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
    .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
  ) timing_i (
    .clk_pixel(clk_pixel), .pixRstN(pixRstN), .video(videoBus.source)
  );

  pixelFetch #(.frameWords(frameWords), .wordAddrWidth(wordAddrWidth)) fetch_i (
    .clk_pixel(clk_pixel), .pixRstN(pixRstN), .video(videoBus.sink),
    .activeScroll(activeScroll), .readData(readData), .readAddr(readAddr),
    .pixelData(pixelData), .de(de), .hsync(hsync), .vsync(vsync)
  );

endmodule

`default_nettype wire

//--- monoVgaTb.sv
`default_nettype none
`timescale 1ns/100ps

module monoVgaTb
  import monoVgaPkg::*;
();

  localparam int hActive      = 64;
  localparam int hFront       = 2;
  localparam int hSync        = 4;
  localparam int hBack        = 3;
  localparam int vActive      = 4;
  localparam int vFront       = 1;
  localparam int vSync        = 2;
  localparam int vBack        = 1;
  localparam int hTotal       = hSync + hBack + hActive + hFront; // 73 cycles.
  localparam int vTotal       = vSync + vBack + vActive + vFront; // 8 lines.
  localparam int frameWords   = hActive * vActive / busDataWidth;
  localparam int patternDepth = 256;

  typedef enum logic [3:0] {
    opWriteWord   = 4'h0,
    opWriteScroll = 4'h1,
    opWriteBad    = 4'h2,
    opExpectFrame = 4'h3,
    opEnd         = 4'hf
  } patternOp;

  logic                    clk_bus = 1'b0;
  logic                    clk_pixel = 1'b0;
  logic                    pix_rst_n;
  logic [busAddrWidth-1:0] busAddress;
  logic [busDataWidth-1:0] busWriteData;
  logic                    busWrite;
  logic                    de;
  logic                    hsync;
  logic                    vsync;
  logic [pixelWidth-1:0]   pixelData;

  logic [busDataWidth-1:0] pattern [0:patternDepth-1];
  logic [busDataWidth-1:0] workWords [0:frameWords-1];
  logic [busDataWidth-1:0] capturedWords [0:frameWords-1];
  int mismatchCount = 0;
  int otherErrors   = 0;
  int cycleCount    = 0;
  int cycleLimit    = 0;
  int framesDone    = 0;
  int framesChecked = 0;
  int pixelCount    = 0;
  int lineCycles    = 0;
  int lineHsync     = 0;
  int lineDe        = 0;
  int frameLines    = 0;
  int frameVsync    = 0;
  int deLines       = 0;
  bit hsyncLast = 1'b1;
  bit vsyncLast = 1'b1;
  bit deLast    = 1'b0;
  bit lineSeen  = 1'b0;
  bit frameSeen = 1'b0;

  monoVga #(
    .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
    .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
  ) dut_i (
    .clk_bus(clk_bus), .clk_pixel(clk_pixel), .pix_rst_n(pix_rst_n),
    .busAddress(busAddress), .busWriteData(busWriteData), .busWrite(busWrite),
    .de(de), .hsync(hsync), .vsync(vsync), .pixelData(pixelData)
  );

  always #10 clk_pixel = ~clk_pixel;
  always #7 clk_bus = ~clk_bus;

  task automatic checkWord(input string name, input logic [busDataWidth-1:0] expected,
                           input logic [busDataWidth-1:0] actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkPixel(input string name, input logic [pixelWidth-1:0] expected,
                            input logic [pixelWidth-1:0] actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    if (actual != expected) begin
      mismatchCount++;
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic checkLevel(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic writeBus(input logic [busAddrWidth-1:0] addr,
                          input logic [busDataWidth-1:0] data);
    @(posedge clk_bus);
    #2;
    busAddress   = addr;
    busWriteData = data;
    busWrite     = 1'b1;
    @(posedge clk_bus);
    #2;
    busWrite = 1'b0; // one-cycle strobe.
  endtask

  task automatic finishRun();
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
    if (mismatchCount == 0 && otherErrors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  function automatic int countRecords();
    int ptr;
    int records;
    ptr = 0;
    records = 0;
    while (ptr < patternDepth - 2 && patternOp'(pattern[ptr][3:0]) != opEnd) begin
      records++;
      ptr += (patternOp'(pattern[ptr][3:0]) == opExpectFrame) ? 3 + int'(pattern[ptr + 2]) : 3;
    end
    return records;
  endfunction

  // line, frame and pixel checks on the aligned outputs.
  always @(negedge clk_pixel) begin : capture
    bit hRise;
    bit vRise;
    hRise = hsync && !hsyncLast;
    vRise = vsync && !vsyncLast;
    if (hRise && lineSeen) begin
      checkCount("line length", hTotal, lineCycles);
      checkCount("hsync cycles per line", hSync, lineHsync);
      if (lineDe != 0) begin
        checkCount("de cycles per line", hActive, lineDe);
        deLines++;
      end
      frameLines++;
    end
    if (vRise) begin
      if (frameSeen) begin
        checkCount("lines per frame", vTotal, frameLines);
        checkCount("vsync cycles per frame", vSync * hTotal, frameVsync);
        checkCount("de lines per frame", vActive, deLines);
      end
      frameSeen  = 1'b1;
      frameLines = 0;
      frameVsync = 0;
      deLines    = 0;
      pixelCount = 0; // pixel 0 is bit 0 of word 0.
    end
    if (hRise) begin
      lineSeen   = 1'b1;
      lineCycles = 0;
      lineHsync  = 0;
      lineDe     = 0;
    end
    if (de && !deLast) begin
      checkCount("de start after hsync rise", hSync + hBack, lineCycles);
    end
    lineCycles++;
    lineHsync  += int'(hsync);
    lineDe     += int'(de);
    frameVsync += int'(vsync);
    if (!de) begin
      checkPixel("pixelData outside de", '0, pixelData);
    end else if (pixelCount < frameWords * busDataWidth) begin
      if (framesChecked > 0 && pixelData !== '0) begin
        checkPixel("pixelData for a set bit", {pixelWidth{1'b1}}, pixelData);
      end
      workWords[pixelCount / busDataWidth][pixelCount % busDataWidth] =
        (pixelData === {pixelWidth{1'b1}});
      pixelCount++;
      if (pixelCount == frameWords * busDataWidth) begin
        capturedWords = workWords;
        framesDone++;
      end
    end
    hsyncLast = hsync;
    vsyncLast = vsync;
    deLast    = de;
  end

  always @(posedge clk_pixel) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      otherErrors++;
      $display("Timeout: the run did not finish within %0d pixel clock cycles", cycleLimit);
      finishRun();
    end
  end

  initial begin : stimulus
    int ptr;
    int target;
    patternOp op;
    pix_rst_n    = 1'b1;
    busAddress   = '0;
    busWriteData = '0;
    busWrite     = 1'b0;
    for (int i = 0; i < patternDepth; i++) begin
      pattern[i] = 32'hf;
    end
    $readmemh("monoVgaPatterns.mem", pattern);
    cycleLimit = (countRecords() + 2) * hTotal * vTotal * 2;
    #1 pix_rst_n = 1'b0;
    repeat (4) @(posedge clk_pixel);
    #2;
    checkLevel("de in reset", 1'b0, de);
    checkLevel("hsync in reset", 1'b1, hsync);
    checkLevel("vsync in reset", 1'b1, vsync);
    checkPixel("pixelData in reset", '0, pixelData);
    pix_rst_n = 1'b1;
    repeat (4) @(posedge clk_bus);
    ptr = 0;
    op  = patternOp'(pattern[0][3:0]);
    while (op != opEnd) begin
      case (op)
        opWriteWord, opWriteScroll, opWriteBad: begin
          writeBus(pattern[ptr + 1][busAddrWidth-1:0], pattern[ptr + 2]);
          ptr += 3;
        end
        opExpectFrame: begin
          target = framesDone + int'(pattern[ptr + 1]); // a full frame after the writes.
          wait (framesDone >= target);
          for (int i = 0; i < frameWords; i++) begin
            checkWord($sformatf("frame word %0d", i), pattern[ptr + 3 + i], capturedWords[i]);
          end
          framesChecked++;
          ptr += 3 + int'(pattern[ptr + 2]);
        end
        default: begin
          otherErrors++;
          $display("Unknown opcode %h in the pattern file at word %0d", pattern[ptr], ptr);
          ptr = patternDepth;
        end
      endcase
      op = (ptr < patternDepth) ? patternOp'(pattern[ptr][3:0]) : opEnd;
    end
    finishRun();
  end

endmodule

`default_nettype wire

//--- monoVgaPatterns.mem
// opcode, byte address, data: 0 word write, 1 scroll write, 2 out-of-range write
// 3 expect frame: frames to wait, word count, expected words; f ends the list
0 000000 80000001
0 000004 f0f0f0f0
0 000008 0000ffff
0 00000c 12345678
0 000010 deadbeef
0 000014 aaaaaaaa
0 000018 00000000
0 00001c ffffffff
1 050000 00000000
3 2 8 80000001 f0f0f0f0 0000ffff 12345678 deadbeef aaaaaaaa 00000000 ffffffff
1 050000 00000003
3 2 8 12345678 deadbeef aaaaaaaa 00000000 ffffffff 80000001 f0f0f0f0 0000ffff
// rejected scroll values and dropped word writes
1 050000 00000008
1 050000 ffffffff
2 000020 55555555
2 00fffc 55555555
3 2 8 12345678 deadbeef aaaaaaaa 00000000 ffffffff 80000001 f0f0f0f0 0000ffff
0 000014 0f0f0f0f
1 050000 00000007
3 2 8 ffffffff 80000001 f0f0f0f0 0000ffff 12345678 deadbeef 0f0f0f0f 00000000
1 050000 00000000
3 2 8 80000001 f0f0f0f0 0000ffff 12345678 deadbeef 0f0f0f0f 00000000 ffffffff
f 0 0

//--- monoVga.f
monoVgaPkg.sv
videoTimingIf.sv
resetSync.sv
hostWritePort.sv
scrollCrossing.sv
frameBufferRam.sv
videoTiming.sv
pixelFetch.sv
monoVga.sv
monoVgaTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= monoVgaTb
FILELIST  ?= monoVga.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
